/* csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int xlen = 32;

    // machine-mode csr addresses
    localparam logic [11:0] addr_mvendorid = 12'hF11;
    localparam logic [11:0] addr_marchid   = 12'hF12;
    localparam logic [11:0] addr_mimpid    = 12'hF13;
    localparam logic [11:0] addr_mhartid   = 12'hF14;
    localparam logic [11:0] addr_mstatus   = 12'h300;
    localparam logic [11:0] addr_misa      = 12'h301;
    localparam logic [11:0] addr_mtvec     = 12'h305;
    localparam logic [11:0] addr_mepc      = 12'h341;
    localparam logic [11:0] addr_mcause    = 12'h342;

    // identity values, ascii tags
    localparam logic [xlen-1:0] mvendorid_value = 32'h4353_5256;  // "CSRV"
    localparam logic [xlen-1:0] marchid_value   = 32'h5233_3249;  // "R32I"
    localparam logic [xlen-1:0] mimpid_value    = 32'h0000_0102;  // impl rev 1.2
    localparam logic [xlen-1:0] mhartid_value   = 32'h0000_0000;  // single hart

    // mpp fixed at machine mode
    localparam logic [xlen-1:0] mstatus_value = 32'h0000_1800;
    // mxl = 1, base isa i
    localparam logic [xlen-1:0] misa_value    = 32'h4000_0100;

    localparam logic [xlen-1:0] mtvec_reset = 32'h0000_1000;

    // low two bits of funct3
    typedef enum logic [1:0] {
        csr_rw = 2'd1,
        csr_rs = 2'd2,
        csr_rc = 2'd3
    } csr_op_e;

    typedef enum logic [2:0] {
        op_idle,    // waiting for op_valid
        op_wait,    // port requested, no grant yet
        op_read,    // address held through the stall
        op_write,   // one-cycle write pulse
        op_finish   // port released, op_done
    } op_state_e;

    typedef enum logic [2:0] {
        trap_idle,
        trap_wait,      // port requested
        trap_wr_epc,    // mepc write pulse
        trap_gap,       // write enable low so the next pulse has an edge
        trap_wr_cause,  // mcause write pulse
        trap_rd_vec,    // mtvec read through the stall
        trap_finish     // redirect pulse
    } trap_state_e;

endpackage

`default_nettype wire

/* csr_file.sv */
`default_nettype none

module csr_file import csr_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            csr_write_enable,
    input  logic [11:0]     csr_read_address,
    input  logic [11:0]     csr_write_address,
    input  logic [xlen-1:0] csr_write_data,
    output logic [xlen-1:0] csr_read_out,
    output logic            csr_ready,
    output logic            csr_valid
);

    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;

    logic [xlen-1:0] read_data;         // decoded value, before the register
    logic            csr_processing;    // high in the second cycle of a read
    logic            write_enable_q;    // last cycle's write enable
    logic            write_edge;

    assign write_edge = csr_write_enable && !write_enable_q;

    // read decode
    always_comb begin
        csr_valid = 1'b1;
        case (csr_read_address)
            addr_mvendorid: read_data = mvendorid_value;
            addr_marchid:   read_data = marchid_value;
            addr_mimpid:    read_data = mimpid_value;
            addr_mhartid:   read_data = mhartid_value;
            addr_mstatus:   read_data = mstatus_value;
            addr_misa:      read_data = misa_value;
            addr_mtvec:     read_data = mtvec;
            addr_mepc:      read_data = mepc;
            addr_mcause:    read_data = mcause;
            default: begin
                read_data = '0;     // unknown reads as zero
                csr_valid = 1'b0;   // and never stalls
            end
        endcase
    end

    // stall for the first cycle of a known read only
    assign csr_ready = !(csr_valid && !csr_processing);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            csr_processing <= 1'b0;
            csr_read_out   <= '0;
            write_enable_q <= 1'b0;
        end else begin
            write_enable_q <= csr_write_enable;
            if (csr_valid && !csr_processing) begin
                csr_processing <= 1'b1;
                csr_read_out   <= read_data;    // visible once ready is back
            end else if (csr_processing) begin
                csr_processing <= 1'b0;
                csr_read_out   <= read_data;
            end
        end
    end

    // writable registers, rising edge of write enable only
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mtvec  <= mtvec_reset;
            mepc   <= '0;
            mcause <= '0;
        end else if (write_edge) begin
            case (csr_write_address)
                addr_mtvec:  mtvec  <= csr_write_data;
                addr_mepc:   mepc   <= csr_write_data;
                addr_mcause: mcause <= csr_write_data;
                default: ;  // read-only or unknown, dropped
            endcase
        end
    end

endmodule

`default_nettype wire

/* csr_op_unit.sv */
`default_nettype none

module csr_op_unit import csr_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            op_valid,
    input  csr_op_e         op_code,
    input  logic [11:0]     op_addr,
    input  logic [xlen-1:0] op_operand,
    output logic            op_busy,
    output logic            op_done,
    output logic [xlen-1:0] op_result,
    output logic            op_illegal,
    output logic            port_req,
    input  logic            port_gnt,
    output logic [11:0]     rd_addr,
    output logic [11:0]     wr_addr,
    output logic [xlen-1:0] wr_data,
    output logic            wr_en,
    input  logic [xlen-1:0] csr_read_out,
    input  logic            csr_ready,
    input  logic            csr_valid
);

    op_state_e       state;
    csr_op_e         code_q;
    logic [11:0]     addr_q;
    logic [xlen-1:0] operand_q;
    logic [xlen-1:0] wdata_q;
    logic [xlen-1:0] new_value;
    logic            read_only;
    logic            will_write;
    logic            illegal_now;
    logic            read_done;

    // bits 11:10 both set marks a read-only csr
    assign read_only   = (addr_q[11:10] == 2'b11);
    assign will_write  = (code_q == csr_rw) || (operand_q != '0);
    assign illegal_now = !csr_valid || (read_only && will_write);
    assign read_done   = (state == op_read) && csr_ready;

    always_comb begin
        case (code_q)
            csr_rs:  new_value = csr_read_out | operand_q;
            csr_rc:  new_value = csr_read_out & ~operand_q;
            default: new_value = operand_q;   // csrrw
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= op_idle;
            op_illegal <= 1'b0;
        end else begin
            case (state)
                op_idle: if (op_valid) begin
                    state      <= op_wait;
                    op_illegal <= 1'b0;
                end
                op_wait: if (port_gnt) state <= op_read;
                op_read: if (csr_ready) begin
                    if (illegal_now) begin
                        op_illegal <= 1'b1;
                        state      <= op_finish;    // skip the write
                    end else if (will_write) begin
                        state <= op_write;
                    end else begin
                        state <= op_finish;
                    end
                end
                op_write:  state <= op_finish;
                op_finish: state <= op_idle;
                default:   state <= op_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == op_idle && op_valid) begin
            code_q    <= op_code;
            addr_q    <= op_addr;
            operand_q <= op_operand;
        end
        if (read_done) begin
            op_result <= illegal_now ? '0 : csr_read_out;   // old value
            wdata_q   <= new_value;
        end
    end

    assign op_busy  = (state != op_idle);
    assign op_done  = (state == op_finish);
    assign port_req = (state == op_wait) || (state == op_read) || (state == op_write);
    assign rd_addr  = (state == op_read) ? addr_q : 12'h000;   // 0 decodes as unknown
    assign wr_addr  = addr_q;
    assign wr_data  = wdata_q;
    assign wr_en    = (state == op_write);

endmodule

`default_nettype wire

/* trap_unit.sv */
`default_nettype none

module trap_unit import csr_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            trap,
    input  logic [xlen-1:0] trap_pc,
    input  logic [xlen-1:0] trap_cause,
    output logic            trap_busy,
    output logic            trap_redirect,
    output logic [xlen-1:0] trap_target,
    output logic            port_req,
    input  logic            port_gnt,
    output logic [11:0]     rd_addr,
    output logic [11:0]     wr_addr,
    output logic [xlen-1:0] wr_data,
    output logic            wr_en,
    input  logic [xlen-1:0] csr_read_out,
    input  logic            csr_ready
);

    trap_state_e     state;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] cause_q;
    logic            cause_phase;

    assign cause_phase = (state == trap_wr_cause);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= trap_idle;
        end else begin
            case (state)
                trap_idle:     if (trap) state <= trap_wait;
                trap_wait:     if (port_gnt) state <= trap_wr_epc;
                trap_wr_epc:   state <= trap_gap;
                trap_gap:      state <= trap_wr_cause;
                trap_wr_cause: state <= trap_rd_vec;
                trap_rd_vec:   if (csr_ready) state <= trap_finish;  // past the stall
                trap_finish:   state <= trap_idle;
                default:       state <= trap_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == trap_idle && trap) begin
            pc_q    <= trap_pc;
            cause_q <= trap_cause;
        end
        if (state == trap_rd_vec && csr_ready) begin
            trap_target <= csr_read_out;
        end
    end

    assign trap_busy     = (state != trap_idle);
    assign trap_redirect = (state == trap_finish);
    assign port_req      = trap_busy && (state != trap_finish);
    assign rd_addr       = (state == trap_rd_vec) ? addr_mtvec : 12'h000;
    assign wr_addr       = cause_phase ? addr_mcause : addr_mepc;
    assign wr_data       = cause_phase ? cause_q : pc_q;
    assign wr_en         = (state == trap_wr_epc) || cause_phase;

endmodule

`default_nettype wire

/* csr_port_arbiter.sv */
`default_nettype none

module csr_port_arbiter import csr_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            trap_req,
    input  logic            op_req,
    input  logic [11:0]     trap_rd_addr,
    input  logic [11:0]     trap_wr_addr,
    input  logic [xlen-1:0] trap_wr_data,
    input  logic            trap_wr_en,
    input  logic [11:0]     op_rd_addr,
    input  logic [11:0]     op_wr_addr,
    input  logic [xlen-1:0] op_wr_data,
    input  logic            op_wr_en,
    output logic            trap_gnt,
    output logic            op_gnt,
    output logic [11:0]     csr_read_address,
    output logic [11:0]     csr_write_address,
    output logic [xlen-1:0] csr_write_data,
    output logic            csr_write_enable
);

    // owner register, held until the owner drops its request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trap_gnt <= 1'b0;
            op_gnt   <= 1'b0;
        end else if (trap_gnt) begin
            if (!trap_req) trap_gnt <= 1'b0;
        end else if (op_gnt) begin
            if (!op_req) op_gnt <= 1'b0;
        end else if (trap_req) begin
            trap_gnt <= 1'b1;   // trap wins a tie
        end else if (op_req) begin
            op_gnt <= 1'b1;
        end
    end

    always_comb begin
        if (trap_gnt) begin
            csr_read_address  = trap_rd_addr;
            csr_write_address = trap_wr_addr;
            csr_write_data    = trap_wr_data;
            csr_write_enable  = trap_wr_en;
        end else if (op_gnt) begin
            csr_read_address  = op_rd_addr;
            csr_write_address = op_wr_addr;
            csr_write_data    = op_wr_data;
            csr_write_enable  = op_wr_en;
        end else begin
            csr_read_address  = 12'h000;    // idle port, no stall
            csr_write_address = 12'h000;
            csr_write_data    = '0;
            csr_write_enable  = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* csr_subsystem.sv */
`default_nettype none

module csr_subsystem import csr_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            op_valid,
    input  csr_op_e         op_code,
    input  logic [11:0]     op_addr,
    input  logic [xlen-1:0] op_operand,
    output logic            op_busy,
    output logic            op_done,
    output logic [xlen-1:0] op_result,
    output logic            op_illegal,
    input  logic            trap,
    input  logic [xlen-1:0] trap_pc,
    input  logic [xlen-1:0] trap_cause,
    output logic            trap_busy,
    output logic            trap_redirect,
    output logic [xlen-1:0] trap_target
);

    // requester side
    logic            op_req, op_gnt, op_wr_en;
    logic [11:0]     op_rd_addr, op_wr_addr;
    logic [xlen-1:0] op_wr_data;
    logic            trap_req, trap_gnt, trap_wr_en;
    logic [11:0]     trap_rd_addr, trap_wr_addr;
    logic [xlen-1:0] trap_wr_data;

    // shared csr port
    logic [11:0]     csr_read_address, csr_write_address;
    logic [xlen-1:0] csr_write_data, csr_read_out;
    logic            csr_write_enable, csr_ready, csr_valid;

    csr_op_unit u_op (
        .clk, .reset,
        .op_valid, .op_code, .op_addr, .op_operand,
        .op_busy, .op_done, .op_result, .op_illegal,
        .port_req (op_req),
        .port_gnt (op_gnt),
        .rd_addr  (op_rd_addr),
        .wr_addr  (op_wr_addr),
        .wr_data  (op_wr_data),
        .wr_en    (op_wr_en),
        .csr_read_out, .csr_ready, .csr_valid
    );

    trap_unit u_trap (
        .clk, .reset,
        .trap, .trap_pc, .trap_cause,
        .trap_busy, .trap_redirect, .trap_target,
        .port_req (trap_req),
        .port_gnt (trap_gnt),
        .rd_addr  (trap_rd_addr),
        .wr_addr  (trap_wr_addr),
        .wr_data  (trap_wr_data),
        .wr_en    (trap_wr_en),
        .csr_read_out, .csr_ready
    );

    csr_port_arbiter u_arb (
        .clk, .reset,
        .trap_req, .op_req,
        .trap_rd_addr, .trap_wr_addr, .trap_wr_data, .trap_wr_en,
        .op_rd_addr, .op_wr_addr, .op_wr_data, .op_wr_en,
        .trap_gnt, .op_gnt,
        .csr_read_address, .csr_write_address, .csr_write_data, .csr_write_enable
    );

    csr_file u_csr (
        .clk, .reset,
        .csr_write_enable, .csr_read_address, .csr_write_address, .csr_write_data,
        .csr_read_out, .csr_ready, .csr_valid
    );

endmodule

`default_nettype wire

/* csr_subsystem_props.sv */
`default_nettype none

// checks on the arbiter grants and the register file stall
module csr_subsystem_props (
    input logic clk,
    input logic reset,
    input logic trap_gnt,
    input logic op_gnt,
    input logic trap_wr_en,
    input logic op_wr_en,
    input logic csr_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    grant_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(trap_gnt && op_gnt))
        else $error("trap and op both hold the csr port");

    // a requester pulses its write enable only while it owns the port
    write_needs_grant: assert property (@(posedge clk) disable iff (reset)
        (!trap_wr_en || trap_gnt) && (!op_wr_en || op_gnt))
        else $error("requester write enable high with no grant");

    single_stall: assert property (@(posedge clk) disable iff (reset)
        !csr_ready |=> csr_ready)
        else $error("csr_ready low for more than one cycle");

endmodule

bind csr_subsystem csr_subsystem_props u_props (
    .clk, .reset, .trap_gnt, .op_gnt, .trap_wr_en, .op_wr_en, .csr_ready
);

`default_nettype wire

/* csr_subsystem_tb.sv */
`default_nettype none

module csr_subsystem_tb import csr_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic            clk;
    logic            reset;
    logic            op_valid;
    csr_op_e         op_code;
    logic [11:0]     op_addr;
    logic [xlen-1:0] op_operand;
    logic            op_busy;
    logic            op_done;
    logic [xlen-1:0] op_result;
    logic            op_illegal;
    logic            trap;
    logic [xlen-1:0] trap_pc;
    logic [xlen-1:0] trap_cause;
    logic            trap_busy;
    logic            trap_redirect;
    logic [xlen-1:0] trap_target;

    logic [8:0][31:0] patterns [$];     // word 0 holds the kind and word 8 the expected target
    int               n_pat = 0;
    int               checks = 0;
    int               errors = 0;
    int               seed = 11107;

    csr_subsystem u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Error: %0t %s expected %h got %h", $time, name, want, got);
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       text;
        logic [31:0] kind, code, addr, operand, pc, cause, result, illegal, target;
        fd = $fopen("csr_subsystem_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open csr_subsystem_patterns.txt");
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (text.len() < 2 || text.getc(0) == "#") continue;   // blank or comment
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h", kind, code, addr, operand,
                        pc, cause, result, illegal, target);
            if (n == 9)
                patterns.push_back({target, illegal, result, cause, pc, operand, addr,
                                    code, kind});
        end
        $fclose(fd);
    endtask

    task automatic run_pattern(input int idx);
        logic [8:0][31:0] row;
        logic             want_op;
        logic             want_trap;
        int               errors_before;
        row           = patterns[idx];
        want_op       = row[0][0];
        want_trap     = row[0][1];  // both bits set fires trap with op_valid
        errors_before = errors;
        repeat ($unsigned($random(seed)) % 4) @(negedge clk);  // idle gap
        while (op_busy || trap_busy) @(negedge clk);
        op_valid   = want_op;
        op_code    = csr_op_e'(row[1][1:0]);
        op_addr    = row[2][11:0];
        op_operand = row[3];
        trap       = want_trap;
        trap_pc    = row[4];
        trap_cause = row[5];
        do begin
            @(negedge clk);
            op_valid = 1'b0;
            trap     = 1'b0;
            if (want_op) check_value("op_busy", 32'(op_busy), 32'h1);
            if (want_trap) check_value("trap_busy", 32'(trap_busy), 32'h1);
            if (want_op && op_done) begin
                check_value("op_result", op_result, row[6]);
                check_value("op_illegal", 32'(op_illegal), row[7]);
                want_op = 1'b0;
            end
            if (want_trap && trap_redirect) begin
                check_value("trap_target", trap_target, row[8]);
                want_trap = 1'b0;
            end
        end while (want_op || want_trap);
        $display("line %0d kind %0d addr %h: %s", idx + 1, row[0], row[2][11:0],
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        reset      = 1'b1;
        op_valid   = 1'b0;
        op_code    = csr_rw;
        op_addr    = '0;
        op_operand = '0;
        trap       = 1'b0;
        trap_pc    = '0;
        trap_cause = '0;
        load_patterns();
        n_pat = patterns.size();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("op_busy/op_done/trap_busy/trap_redirect",
                    32'({op_busy, op_done, trap_busy, trap_redirect}), 32'h0);
        if (n_pat == 0) begin
            $display("no usable lines found in csr_subsystem_patterns.txt");
            errors++;
        end
        for (int i = 0; i < n_pat; i++) run_pattern(i);
        $display("%0d lines, %0d checks, %0d errors", n_pat, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // a contention line takes about 20 cycles
    initial begin
        wait (n_pat > 0);
        repeat (n_pat * 40) @(posedge clk);
        $display("watchdog expired, %0d lines did not finish in %0d cycles", n_pat, n_pat * 40);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* csr_subsystem_patterns.txt */
# kind (1 op, 2 trap, 3 both) code (1 rw, 2 rs, 3 rc) addr operand trap_pc trap_cause
# then expected op_result op_illegal trap_target, all hex
1 2 f11 00000000 00000000 00000000 43535256 0 00000000
1 2 f12 00000000 00000000 00000000 52333249 0 00000000
1 2 f13 00000000 00000000 00000000 00000102 0 00000000
1 2 f14 00000000 00000000 00000000 00000000 0 00000000
1 2 300 00000000 00000000 00000000 00001800 0 00000000
1 2 301 00000000 00000000 00000000 40000100 0 00000000
1 2 305 00000000 00000000 00000000 00001000 0 00000000
1 1 305 00002000 00000000 00000000 00001000 0 00000000
1 2 305 00000103 00000000 00000000 00002000 0 00000000
1 3 305 00000101 00000000 00000000 00002103 0 00000000
1 2 305 00000000 00000000 00000000 00002002 0 00000000
1 2 341 00000000 00000000 00000000 00000000 0 00000000
1 1 341 80000040 00000000 00000000 00000000 0 00000000
1 3 341 00000040 00000000 00000000 80000040 0 00000000
1 2 341 0000000c 00000000 00000000 80000000 0 00000000
1 2 341 00000000 00000000 00000000 8000000c 0 00000000
1 1 342 0000000b 00000000 00000000 00000000 0 00000000
1 2 342 80000000 00000000 00000000 0000000b 0 00000000
1 3 342 0000000f 00000000 00000000 8000000b 0 00000000
1 2 342 00000000 00000000 00000000 80000000 0 00000000
1 1 7c0 12345678 00000000 00000000 00000000 1 00000000
1 1 f11 ffffffff 00000000 00000000 00000000 1 00000000
1 2 f11 00000000 00000000 00000000 43535256 0 00000000
1 2 f14 00000001 00000000 00000000 00000000 1 00000000
2 0 000 00000000 00000400 00000002 00000000 0 00002002
1 2 341 00000000 00000000 00000000 00000400 0 00000000
1 2 342 00000000 00000000 00000000 00000002 0 00000000
1 1 305 00003000 00000000 00000000 00002002 0 00000000
2 0 000 00000000 00000508 0000000b 00000000 0 00003000
1 2 341 00000000 00000000 00000000 00000508 0 00000000
1 2 342 00000000 00000000 00000000 0000000b 0 00000000
3 2 341 00000000 00000620 00000005 00000620 0 00003000
3 2 342 00000000 00000730 00000007 00000007 0 00003000
3 1 305 00004000 00000840 00000003 00003000 0 00003000
1 2 341 00000000 00000000 00000000 00000840 0 00000000
1 2 305 00000000 00000000 00000000 00004000 0 00000000
2 0 000 00000000 00000900 00000001 00000000 0 00004000
1 2 342 00000000 00000000 00000000 00000001 0 00000000

/* csr_subsystem.f */
csr_pkg.sv
csr_file.sv
csr_op_unit.sv
trap_unit.sv
csr_port_arbiter.sv
csr_subsystem.sv
csr_subsystem_props.sv
csr_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it and search the output for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps --top-module csr_subsystem_tb \
    -f csr_subsystem.f &&
./obj_dir/Vcsr_subsystem_tb | tee /dev/stderr | grep -qx "test passed" || exit 1
